/* build.f */
+incdir+.
exe_pkg.sv
exe_bypass_if.sv
exe_alu.sv
exe_branch.sv
exe_mul.sv
exe_forward.sv
exe_stage.sv
tb_exe_stage.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_exe_stage -o sim_exe_stage

./obj_dir/sim_exe_stage > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log

/* tb_exe_stage.sv */
`include "exe_macros.svh"

module tb_exe_stage import exe_pkg::*; ();

    localparam int NUM_TESTS = 6;

    logic      clk;
    logic      rst_n;
    logic      flush_in;
    logic      eu0_en;
    exe_unit_t eu0_unit;
    exe_op_t   eu0_op;
    logic      eu0_use_imm;
    reg_addr_t eu0_rd;
    reg_addr_t eu0_rj;
    reg_addr_t eu0_rk;
    data_t     eu0_imm;
    pc_t       eu0_pc;
    pc_t       eu0_pc_next;
    data_t     data00;
    data_t     data01;
    logic      eu1_en;
    exe_op_t   eu1_op;
    logic      eu1_use_imm;
    reg_addr_t eu1_rd;
    reg_addr_t eu1_rj;
    reg_addr_t eu1_rk;
    data_t     eu1_imm;
    data_t     data10;
    data_t     data11;
    logic      en_out0;
    reg_addr_t addr_out0;
    data_t     data_out0;
    logic      en_out1;
    reg_addr_t addr_out1;
    data_t     data_out1;
    logic      branch_valid;
    logic      branch_taken;
    pc_t       branch_pc;
    pc_t       correct_pc_next;
    logic      flush;

    // bundle under construction
    logic      s0_en;
    exe_unit_t s0_unit;
    exe_op_t   s0_op;
    logic      s0_use_imm;
    reg_addr_t s0_rd;
    reg_addr_t s0_rj;
    reg_addr_t s0_rk;
    data_t     s0_imm;
    pc_t       s0_pc;
    pc_t       s0_pcn;
    logic      s1_en;
    exe_op_t   s1_op;
    logic      s1_use_imm;
    reg_addr_t s1_rd;
    reg_addr_t s1_rj;
    reg_addr_t s1_rk;
    data_t     s1_imm;

    // architectural model and cycle of the last write per register
    data_t     arch [32];
    int        wr_cyc [32];

    // expected results indexed by due cycle
    logic      exp0_v [16];
    reg_addr_t exp0_rd [16];
    data_t     exp0_d [16];
    logic      exp1_v [16];
    reg_addr_t exp1_rd [16];
    data_t     exp1_d [16];
    logic      expb_v [16];
    logic      expb_taken [16];
    logic      expb_flush [16];
    pc_t       expb_pc [16];
    pc_t       expb_next [16];

    int        cyc;
    int        err_count;
    int        pass_cnt;
    int        fail_cnt;
    logic      flush_pending;
    logic      wb_flush_now;
    string     cur_test;
    int unsigned seed_dummy;

    exe_stage exe_stage_i (.*);

    always begin
        #2 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 200 * 4);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    // output monitor, sampled mid-cycle
    always @(posedge clk) begin
        int i;
        cyc = cyc + 1;
        #3;
        i = cyc % 16;
        check_val("en_out0", 32'(exp0_v[i]), 32'(en_out0));
        if (exp0_v[i] && en_out0) begin
            check_val("addr_out0", 32'(exp0_rd[i]), 32'(addr_out0));
            check_val("data_out0", exp0_d[i], data_out0);
        end
        check_val("en_out1", 32'(exp1_v[i]), 32'(en_out1));
        if (exp1_v[i] && en_out1) begin
            check_val("addr_out1", 32'(exp1_rd[i]), 32'(addr_out1));
            check_val("data_out1", exp1_d[i], data_out1);
        end
        check_val("branch_valid", 32'(expb_v[i]), 32'(branch_valid));
        check_val("flush", 32'(expb_v[i] && expb_flush[i]), 32'(flush));
        if (expb_v[i] && branch_valid) begin
            check_val("branch_taken", 32'(expb_taken[i]), 32'(branch_taken));
            check_val("branch_pc", expb_pc[i], branch_pc);
            check_val("correct_pc_next", expb_next[i], correct_pc_next);
        end
        exp0_v[i] = 1'b0;
        exp1_v[i] = 1'b0;
        expb_v[i] = 1'b0;
    end

    function automatic data_t alu_ref(exe_op_t op, data_t a, data_t b);
        case (alu_op_t'(op))
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            default:  return b;
        endcase
    endfunction

    function automatic data_t mul_ref(exe_op_t op, data_t a, data_t b);
        logic [63:0] p;
        if (op[1]) begin
            p = $unsigned($signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b}));
        end else begin
            p = {32'b0, a} * {32'b0, b};
        end
        return op[0] ? p[63:32] : p[31:0];
    endfunction

    // taken follows the condition alone, whatever the target
    function automatic logic branch_cond(exe_op_t op, data_t a, data_t b);
        case (op)
            4'(`EXE_BR_BEQ):  return (a == b);
            4'(`EXE_BR_BNE):  return (a != b);
            4'(`EXE_BR_BLT):  return ($signed(a) < $signed(b));
            4'(`EXE_BR_BGE):  return ($signed(a) >= $signed(b));
            4'(`EXE_BR_BLTU): return (a < b);
            4'(`EXE_BR_BGEU): return (a >= b);
            default:          return 1'b1;
        endcase
    endfunction

    function automatic pc_t next_pc(exe_op_t op, data_t a, data_t b, pc_t pc, data_t imm);
        if (!branch_cond(op, a, b)) begin
            return pc + 32'd4;
        end
        return ((op == 4'(`EXE_BR_JIRL)) ? a : pc) + imm;
    endfunction

    // register file lags writes by three cycles; stale values expose missing forwards
    function automatic data_t rf_value(reg_addr_t r);
        if (r == 5'd0) begin
            return 32'd0;
        end
        if (cyc >= wr_cyc[r] + 3) begin
            return arch[r];
        end
        return ~arch[r];
    endfunction

    task automatic set_eu0(exe_unit_t unit, exe_op_t op, reg_addr_t rd, reg_addr_t rj,
                           reg_addr_t rk, logic use_imm, data_t imm);
        s0_en      = 1'b1;
        s0_unit    = unit;
        s0_op      = op;
        s0_rd      = rd;
        s0_rj      = rj;
        s0_rk      = rk;
        s0_use_imm = use_imm;
        s0_imm     = imm;
    endtask

    task automatic set_eu1(exe_op_t op, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk,
                           logic use_imm, data_t imm);
        s1_en      = 1'b1;
        s1_op      = op;
        s1_rd      = rd;
        s1_rj      = rj;
        s1_rk      = rk;
        s1_use_imm = use_imm;
        s1_imm     = imm;
    endtask

    task automatic issue_bundle();
        data_t a0;
        data_t b0;
        data_t a1;
        data_t b1;
        data_t res0;
        data_t res1;
        pc_t   nxt;
        logic  discard;
        logic  mispred;
        logic  wr0;
        logic  wr1;
        int    due;
        int    bi;
        due     = (cyc + 2) % 16;
        bi      = (cyc + 1) % 16;
        discard = flush_pending || wb_flush_now;
        a0 = arch[s0_rj];
        b0 = arch[s0_rk];
        a1 = arch[s1_rj];
        b1 = arch[s1_rk];
        eu0_en = s0_en;
        eu0_unit = s0_unit;
        eu0_op = s0_op;
        eu0_use_imm = s0_use_imm;
        eu0_rd = s0_rd;
        eu0_rj = s0_rj;
        eu0_rk = s0_rk;
        eu0_imm = s0_imm;
        eu0_pc = s0_pc;
        eu0_pc_next = s0_pcn;
        data00 = rf_value(s0_rj);
        data01 = rf_value(s0_rk);
        eu1_en = s1_en;
        eu1_op = s1_op;
        eu1_use_imm = s1_use_imm;
        eu1_rd = s1_rd;
        eu1_rj = s1_rj;
        eu1_rk = s1_rk;
        eu1_imm = s1_imm;
        data10 = rf_value(s1_rj);
        data11 = rf_value(s1_rk);
        flush_in = wb_flush_now;
        mispred = 1'b0;
        wr0 = 1'b0;
        wr1 = 1'b0;
        res0 = '0;
        res1 = '0;
        if (!discard && s0_en) begin
            if (s0_unit == unit_alu) begin
                res0 = alu_ref(s0_op, a0, s0_use_imm ? s0_imm : b0);
                wr0 = 1'b1;
            end else if (s0_unit == unit_mul) begin
                res0 = mul_ref(s0_op, a0, b0);
                wr0 = 1'b1;
            end else begin
                nxt = next_pc(s0_op, a0, b0, s0_pc, s0_imm);
                mispred = (nxt != s0_pcn);
                expb_v[bi] = 1'b1;
                expb_taken[bi] = branch_cond(s0_op, a0, b0);
                expb_pc[bi] = s0_pc;
                expb_next[bi] = nxt;
                expb_flush[bi] = mispred;
                if (s0_op == 4'(`EXE_BR_BL) || s0_op == 4'(`EXE_BR_JIRL)) begin
                    res0 = s0_pc + 32'd4;
                    wr0 = 1'b1;
                end
            end
        end
        if (!discard && s1_en && !mispred) begin
            res1 = alu_ref(s1_op, a1, s1_use_imm ? s1_imm : b1);
            wr1 = 1'b1;
        end
        if (wr0) begin
            exp0_v[due] = 1'b1;
            exp0_rd[due] = s0_rd;
            exp0_d[due] = res0;
        end
        if (wr1) begin
            exp1_v[due] = 1'b1;
            exp1_rd[due] = s1_rd;
            exp1_d[due] = res1;
        end
        if (wb_flush_now) begin
            exp0_v[bi] = 1'b0;
            exp1_v[bi] = 1'b0;
        end
        // eu1 is younger, so its write lands last
        if (wr0 && s0_rd != 5'd0) begin
            arch[s0_rd] = res0;
            wr_cyc[s0_rd] = cyc;
        end
        if (wr1 && s1_rd != 5'd0) begin
            arch[s1_rd] = res1;
            wr_cyc[s1_rd] = cyc;
        end
        flush_pending = mispred;
        s0_en = 1'b0;
        s1_en = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic load_regs(reg_addr_t ra, data_t va, reg_addr_t rb, data_t vb);
        set_eu0(unit_alu, 4'(alu_lui), ra, 5'd0, 5'd0, 1'b1, va);
        set_eu1(4'(alu_lui), rb, 5'd0, 5'd0, 1'b1, vb);
        issue_bundle();
    endtask

    function automatic reg_addr_t rnd_reg(int lo, int hi);
        return 5'($urandom_range(hi, lo));
    endfunction

    task automatic end_test(int errs_before);
        repeat (3) issue_bundle();
        if (err_count == errs_before) begin
            pass_cnt++;
            $display("%s: ok", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", cur_test, err_count - errs_before);
        end
    endtask

    task automatic test_reset();
        int e;
        e = err_count;
        cur_test = "reset";
        rst_n = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #1;
            if (en_out0 || en_out1 || flush || branch_valid) begin
                $display("outputs active while reset is held");
                err_count++;
            end
        end
        rst_n = 1'b1;
        end_test(e);
    endtask

    task automatic test_alu();
        int e;
        e = err_count;
        cur_test = "alu";
        for (int op = 0; op < 12; op++) begin
            for (int imm = 0; imm < 2; imm++) begin
                set_eu0(unit_alu, 4'(op), rnd_reg(10, 15), rnd_reg(1, 8), rnd_reg(1, 8),
                        1'(imm), $urandom);
                set_eu1(4'(op), rnd_reg(10, 15), rnd_reg(1, 8), rnd_reg(1, 8),
                        1'(imm), $urandom);
                issue_bundle();
            end
        end
        // rd 0 result must not reach a reader of r0
        set_eu0(unit_alu, 4'(alu_lui), 5'd0, 5'd0, 5'd0, 1'b1, 32'h1234_5678);
        issue_bundle();
        set_eu0(unit_alu, 4'(alu_or), 5'd9, 5'd0, 5'd1, 1'b0, 32'd0);
        set_eu1(4'(alu_add), 5'd10, 5'd0, 5'd0, 1'b0, 32'd0);
        issue_bundle();
        end_test(e);
    endtask

    task automatic test_forward();
        int e;
        e = err_count;
        cur_test = "forward";
        set_eu0(unit_alu, 4'(alu_add), 5'd12, 5'd1, 5'd2, 1'b0, 32'd0);
        set_eu1(4'(alu_add), 5'd13, 5'd3, 5'd4, 1'b0, 32'd0);
        issue_bundle();
        set_eu0(unit_alu, 4'(alu_sub), 5'd14, 5'd13, 5'd12, 1'b0, 32'd0);
        set_eu1(4'(alu_or), 5'd15, 5'd12, 5'd13, 1'b0, 32'd0);
        issue_bundle();
        issue_bundle();
        set_eu0(unit_alu, 4'(alu_xor), 5'd11, 5'd14, 5'd15, 1'b0, 32'd0);
        issue_bundle();
        // same rd in both slots
        set_eu0(unit_alu, 4'(alu_add), 5'd16, 5'd1, 5'd2, 1'b0, 32'd0);
        set_eu1(4'(alu_sub), 5'd16, 5'd3, 5'd4, 1'b0, 32'd0);
        issue_bundle();
        set_eu0(unit_alu, 4'(alu_add), 5'd17, 5'd16, 5'd0, 1'b0, 32'd0);
        issue_bundle();
        set_eu1(4'(alu_add), 5'd18, 5'd16, 5'd0, 1'b0, 32'd0);
        issue_bundle();
        repeat (24) begin
            set_eu0(unit_alu, 4'($urandom_range(11, 0)), rnd_reg(0, 15), rnd_reg(0, 15),
                    rnd_reg(0, 15), 1'($urandom_range(1, 0)), $urandom);
            set_eu1(4'($urandom_range(11, 0)), rnd_reg(0, 15), rnd_reg(0, 15),
                    rnd_reg(0, 15), 1'($urandom_range(1, 0)), $urandom);
            issue_bundle();
        end
        end_test(e);
    endtask

    task automatic test_mul();
        int       e;
        exe_op_t  ops [3];
        e = err_count;
        cur_test = "mul";
        ops[0] = 4'd2;
        ops[1] = 4'd3;
        ops[2] = 4'd1;
        load_regs(5'd20, 32'd0, 5'd21, 32'hffff_ffff);
        load_regs(5'd22, 32'h8000_0000, 5'd23, 32'd1);
        load_regs(5'd24, 32'h7fff_ffff, 5'd25, $urandom);
        for (int k = 0; k < 3; k++) begin
            for (int i = 20; i < 26; i++) begin
                for (int j = 20; j < 26; j++) begin
                    set_eu0(unit_mul, ops[k], 5'd26, 5'(i), 5'(j), 1'b0, 32'd0);
                    issue_bundle();
                end
            end
        end
        repeat (10) begin
            set_eu0(unit_mul, ops[$urandom_range(2, 0)], 5'd27, rnd_reg(1, 8),
                    rnd_reg(1, 8), 1'b0, 32'd0);
            set_eu1(4'(alu_add), 5'd11, rnd_reg(1, 8), rnd_reg(1, 8), 1'b0, 32'd0);
            issue_bundle();
        end
        end_test(e);
    endtask

    task automatic test_branch();
        int    e;
        data_t a;
        data_t b;
        pc_t   nxt;
        e = err_count;
        cur_test = "branch";
        for (int op = `EXE_BR_JIRL; op <= `EXE_BR_BGEU; op++) begin
            for (int k = 0; k < 4; k++) begin
                a = $urandom;
                b = (k[0]) ? a : $urandom;
                load_regs(5'd5, a, 5'd6, b);
                set_eu0(unit_br, 4'(op), 5'd30, 5'd5, 5'd6, 1'b0,
                        (32'($urandom_range(63, 0)) - 32'd32) << 2);
                s0_pc = $urandom & 32'hffff_fffc;
                nxt = next_pc(s0_op, a, b, s0_pc, s0_imm);
                s0_pcn = k[1] ? nxt + 32'd8 : nxt;
                set_eu1(4'(alu_add), 5'd31, 5'd1, 5'd2, 1'b0, 32'd0);
                issue_bundle();
                set_eu0(unit_alu, 4'(alu_or), 5'd29, 5'd30, 5'd0, 1'b0, 32'd0);
                set_eu1(4'(alu_add), 5'd28, 5'd31, 5'd3, 1'b0, 32'd0);
                issue_bundle();
            end
        end
        end_test(e);
    endtask

    task automatic test_wb_flush();
        int    e;
        data_t arch_save [32];
        int    wr_save [32];
        e = err_count;
        cur_test = "wb_flush";
        for (int r = 0; r < 32; r++) begin
            arch_save[r] = arch[r];
            wr_save[r] = wr_cyc[r];
        end
        set_eu0(unit_mul, 4'd2, 5'd18, 5'd1, 5'd2, 1'b0, 32'd0);
        set_eu1(4'(alu_add), 5'd19, 5'd3, 5'd4, 1'b0, 32'd0);
        issue_bundle();
        wb_flush_now = 1'b1;
        set_eu0(unit_alu, 4'(alu_xor), 5'd17, 5'd1, 5'd4, 1'b0, 32'd0);
        set_eu1(4'(alu_sub), 5'd16, 5'd2, 5'd3, 1'b0, 32'd0);
        issue_bundle();
        wb_flush_now = 1'b0;
        for (int r = 0; r < 32; r++) begin
            arch[r] = arch_save[r];
            wr_cyc[r] = wr_save[r];
        end
        issue_bundle();
        set_eu0(unit_alu, 4'(alu_add), 5'd14, 5'd18, 5'd19, 1'b0, 32'd0);
        set_eu1(4'(alu_or), 5'd15, 5'd17, 5'd16, 1'b0, 32'd0);
        issue_bundle();
        end_test(e);
    endtask

    initial begin
        seed_dummy = $urandom(32'h88de);
        clk = 1'b0;
        rst_n = 1'b0;
        cyc = 0;
        err_count = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        flush_pending = 1'b0;
        wb_flush_now = 1'b0;
        for (int i = 0; i < 16; i++) begin
            exp0_v[i] = 1'b0;
            exp1_v[i] = 1'b0;
            expb_v[i] = 1'b0;
        end
        arch[0] = 32'd0;
        wr_cyc[0] = -100;
        for (int r = 1; r < 32; r++) begin
            arch[r] = $urandom;
            wr_cyc[r] = -100;
        end
        s0_en = 1'b0;
        s0_unit = unit_alu;
        s0_op = '0;
        s0_use_imm = 1'b0;
        s0_rd = '0;
        s0_rj = '0;
        s0_rk = '0;
        s0_imm = '0;
        s0_pc = '0;
        s0_pcn = '0;
        s1_en = 1'b0;
        s1_op = '0;
        s1_use_imm = 1'b0;
        s1_rd = '0;
        s1_rj = '0;
        s1_rk = '0;
        s1_imm = '0;
        flush_in = 1'b0;
        eu0_en = 1'b0;
        eu0_unit = unit_alu;
        eu0_op = '0;
        eu0_use_imm = 1'b0;
        eu0_rd = '0;
        eu0_rj = '0;
        eu0_rk = '0;
        eu0_imm = '0;
        eu0_pc = '0;
        eu0_pc_next = '0;
        data00 = '0;
        data01 = '0;
        eu1_en = 1'b0;
        eu1_op = '0;
        eu1_use_imm = 1'b0;
        eu1_rd = '0;
        eu1_rj = '0;
        eu1_rk = '0;
        eu1_imm = '0;
        data10 = '0;
        data11 = '0;
        test_reset();
        test_alu();
        test_forward();
        test_mul();
        test_branch();
        test_wb_flush();
        $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_count);
        if (fail_cnt == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* exe_stage.sv */
module exe_stage import exe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush_in,

    input  logic      eu0_en,
    input  exe_unit_t eu0_unit,
    input  exe_op_t   eu0_op,
    input  logic      eu0_use_imm,
    input  reg_addr_t eu0_rd,
    input  reg_addr_t eu0_rj,
    input  reg_addr_t eu0_rk,
    input  data_t     eu0_imm,
    input  pc_t       eu0_pc,
    input  pc_t       eu0_pc_next,
    input  data_t     data00,
    input  data_t     data01,

    input  logic      eu1_en,
    input  exe_op_t   eu1_op,
    input  logic      eu1_use_imm,
    input  reg_addr_t eu1_rd,
    input  reg_addr_t eu1_rj,
    input  reg_addr_t eu1_rk,
    input  data_t     eu1_imm,
    input  data_t     data10,
    input  data_t     data11,

    output logic      en_out0,
    output reg_addr_t addr_out0,
    output data_t     data_out0,
    output logic      en_out1,
    output reg_addr_t addr_out1,
    output data_t     data_out1,

    output logic      branch_valid,
    output logic      branch_taken,
    output pc_t       branch_pc,
    output pc_t       correct_pc_next,
    output logic      flush
);

    logic      eu0_go;
    logic      eu1_go;
    logic      eu0_alu_en;
    logic      eu0_mul_en;
    logic      eu0_br_en;

    data_t     eu0_sr0;
    data_t     eu0_sr1;
    data_t     eu1_sr0;
    data_t     eu1_sr1;
    data_t     eu0_alu_sr1;
    data_t     eu1_alu_sr1;
    data_t     alu0_result;
    data_t     alu1_result;

    logic      br_taken;
    pc_t       br_target;
    data_t     br_link;
    logic      br_link_en;
    logic      br_mispredict;

    logic      mul_clear;
    logic      mul_en;
    reg_addr_t mul_rd;
    data_t     mul_result;

    // final stage of the eu0 alu/branch path
    logic      fin_en0;
    reg_addr_t fin_rd0;
    data_t     fin_data0;

    exe_bypass_if bypass_mid ();
    exe_bypass_if bypass_out ();

    // bundle arriving under a mispredict flush is dropped
    assign eu0_go = eu0_en && !flush;
    assign eu1_go = eu1_en && !flush;

    assign eu0_alu_en = eu0_go && (eu0_unit == unit_alu);
    assign eu0_mul_en = eu0_go && (eu0_unit == unit_mul);
    assign eu0_br_en  = eu0_go && (eu0_unit == unit_br);

    assign eu0_alu_sr1 = eu0_use_imm ? eu0_imm : eu0_sr1;
    assign eu1_alu_sr1 = eu1_use_imm ? eu1_imm : eu1_sr1;

    exe_forward u_forward (
        .eu0_rj    (eu0_rj),
        .eu0_rk    (eu0_rk),
        .eu1_rj    (eu1_rj),
        .eu1_rk    (eu1_rk),
        .data00    (data00),
        .data01    (data01),
        .data10    (data10),
        .data11    (data11),
        .mid       (bypass_mid),
        .out_stage (bypass_out),
        .eu0_sr0   (eu0_sr0),
        .eu0_sr1   (eu0_sr1),
        .eu1_sr0   (eu1_sr0),
        .eu1_sr1   (eu1_sr1)
    );

    exe_alu u_alu0 (
        .op     (alu_op_t'(eu0_op)),
        .sr0    (eu0_sr0),
        .sr1    (eu0_alu_sr1),
        .result (alu0_result)
    );

    exe_alu u_alu1 (
        .op     (alu_op_t'(eu1_op)),
        .sr0    (eu1_sr0),
        .sr1    (eu1_alu_sr1),
        .result (alu1_result)
    );

    exe_branch u_branch (
        .en         (eu0_br_en),
        .op         (branch_op_t'(eu0_op)),
        .pc         (eu0_pc),
        .pc_next    (eu0_pc_next),
        .sr0        (eu0_sr0),
        .sr1        (eu0_sr1),
        .imm        (eu0_imm),
        .taken      (br_taken),
        .target     (br_target),
        .link       (br_link),
        .link_en    (br_link_en),
        .mispredict (br_mispredict)
    );

    assign mul_clear = flush || flush_in;

    exe_mul u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (mul_clear),
        .en     (eu0_mul_en),
        .op     (eu0_op),
        .rd     (eu0_rd),
        .sr0    (eu0_sr0),
        .sr1    (eu0_sr1),
        .en_out (mul_en),
        .rd_out (mul_rd),
        .result (mul_result)
    );

    // middle stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass_mid.en0 <= 1'b0;
            bypass_mid.en1 <= 1'b0;
            branch_valid   <= 1'b0;
            flush          <= 1'b0;
        end else if (flush_in) begin
            bypass_mid.en0 <= 1'b0;
            bypass_mid.en1 <= 1'b0;
            branch_valid   <= 1'b0;
            flush          <= 1'b0;
        end else begin
            bypass_mid.en0 <= eu0_alu_en || br_link_en;
            bypass_mid.en1 <= eu1_go;
            branch_valid   <= eu0_br_en;
            flush          <= br_mispredict;
        end
    end

    always_ff @(posedge clk) begin
        bypass_mid.rd0   <= eu0_rd;
        bypass_mid.data0 <= eu0_alu_en ? alu0_result : br_link;
        bypass_mid.rd1   <= eu1_rd;
        bypass_mid.data1 <= alu1_result;
        branch_taken     <= br_taken;
        branch_pc        <= eu0_pc;
        correct_pc_next  <= br_taken ? br_target : br_link;
    end

    // final stage; the eu1 partner of a mispredicted branch dies here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fin_en0 <= 1'b0;
            en_out1 <= 1'b0;
        end else if (flush_in) begin
            fin_en0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            fin_en0 <= bypass_mid.en0;
            en_out1 <= bypass_mid.en1 && !flush;
        end
    end

    always_ff @(posedge clk) begin
        fin_rd0   <= bypass_mid.rd0;
        fin_data0 <= bypass_mid.data0;
        addr_out1 <= bypass_mid.rd1;
        data_out1 <= bypass_mid.data1;
    end

    // eu0 issues one unit per cycle, so mul and alu never land together
    assign en_out0   = fin_en0 || mul_en;
    assign addr_out0 = mul_en ? mul_rd : fin_rd0;
    assign data_out0 = mul_en ? mul_result : fin_data0;

    assign bypass_out.en0   = en_out0;
    assign bypass_out.rd0   = addr_out0;
    assign bypass_out.data0 = data_out0;
    assign bypass_out.en1   = en_out1;
    assign bypass_out.rd1   = addr_out1;
    assign bypass_out.data1 = data_out1;

endmodule

/* exe_forward.sv */
module exe_forward import exe_pkg::*; (
    input  reg_addr_t           eu0_rj,
    input  reg_addr_t           eu0_rk,
    input  reg_addr_t           eu1_rj,
    input  reg_addr_t           eu1_rk,
    input  data_t               data00,
    input  data_t               data01,
    input  data_t               data10,
    input  data_t               data11,
    exe_bypass_if.reader        mid,
    exe_bypass_if.reader        out_stage,
    output data_t               eu0_sr0,
    output data_t               eu0_sr1,
    output data_t               eu1_sr0,
    output data_t               eu1_sr1
);

    // entry 0 is the youngest result
    logic [3:0] byp_en;
    reg_addr_t  byp_rd [4];
    data_t      byp_data [4];

    assign byp_en = {out_stage.en0, out_stage.en1, mid.en0, mid.en1};

    assign byp_rd[0]   = mid.rd1;
    assign byp_rd[1]   = mid.rd0;
    assign byp_rd[2]   = out_stage.rd1;
    assign byp_rd[3]   = out_stage.rd0;
    assign byp_data[0] = mid.data1;
    assign byp_data[1] = mid.data0;
    assign byp_data[2] = out_stage.data1;
    assign byp_data[3] = out_stage.data0;

    function automatic data_t select_src(input reg_addr_t rs, input data_t rf_val);
        data_t val;
        val = rf_val;
        // oldest first so the youngest match is left standing
        for (int i = 3; i >= 0; i--) begin
            if (byp_en[i] && (byp_rd[i] == rs) && (rs != '0)) begin
                val = byp_data[i];
            end
        end
        return val;
    endfunction

    always_comb begin
        eu0_sr0 = select_src(eu0_rj, data00);
        eu0_sr1 = select_src(eu0_rk, data01);
        eu1_sr0 = select_src(eu1_rj, data10);
        eu1_sr1 = select_src(eu1_rk, data11);
    end

endmodule

/* exe_mul.sv */
module exe_mul import exe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  logic      en,
    input  exe_op_t   op,
    input  reg_addr_t rd,
    input  data_t     sr0,
    input  data_t     sr1,
    output logic      en_out,
    output reg_addr_t rd_out,
    output data_t     result
);

    logic        sign_op;
    logic [31:0] pp_ll_d;
    logic [31:0] pp_lh_d;
    logic [31:0] pp_hl_d;
    logic [31:0] pp_hh_d;
    logic [31:0] corr_d;

    logic        s1_en;
    logic        s1_hi;
    reg_addr_t   s1_rd;
    logic [31:0] s1_ll;
    logic [31:0] s1_lh;
    logic [31:0] s1_hl;
    logic [31:0] s1_hh;
    logic [31:0] s1_corr;
    logic [63:0] sum;

    assign sign_op = op[1];

    // unsigned 16x16 partial products
    assign pp_ll_d = sr0[15:0] * sr1[15:0];
    assign pp_lh_d = sr0[15:0] * sr1[31:16];
    assign pp_hl_d = sr0[31:16] * sr1[15:0];
    assign pp_hh_d = sr0[31:16] * sr1[31:16];

    // negative weight of each sign bit, taken off the high word
    assign corr_d = ((sign_op && sr0[31]) ? sr1 : 32'b0)
                  + ((sign_op && sr1[31]) ? sr0 : 32'b0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_en  <= 1'b0;
            en_out <= 1'b0;
        end else if (clear) begin
            s1_en  <= 1'b0;
            en_out <= 1'b0;
        end else begin
            s1_en  <= en;
            en_out <= s1_en;
        end
    end

    always_ff @(posedge clk) begin
        s1_hi   <= op[0];
        s1_rd   <= rd;
        s1_ll   <= pp_ll_d;
        s1_lh   <= pp_lh_d;
        s1_hl   <= pp_hl_d;
        s1_hh   <= pp_hh_d;
        s1_corr <= corr_d;
    end

    assign sum = {s1_hh, s1_ll}
               + {16'b0, s1_lh, 16'b0}
               + {16'b0, s1_hl, 16'b0}
               - {s1_corr, 32'b0};

    always_ff @(posedge clk) begin
        rd_out <= s1_rd;
        result <= s1_hi ? sum[63:32] : sum[31:0];
    end

endmodule

/* exe_branch.sv */
`include "exe_macros.svh"

module exe_branch import exe_pkg::*; (
    input  logic       en,
    input  branch_op_t op,
    input  pc_t        pc,
    input  pc_t        pc_next,
    input  data_t      sr0,
    input  data_t      sr1,
    input  data_t      imm,
    output logic       taken,
    output pc_t        target,
    output data_t      link,
    output logic       link_en,
    output logic       mispredict
);

    logic cond;
    pc_t  actual_next;

    always_comb begin
        case (op)
            br_jirl, br_b, br_bl: begin
                cond = 1'b1;
            end
            br_beq: begin
                cond = sr0 == sr1;
            end
            br_bne: begin
                cond = sr0 != sr1;
            end
            br_blt: begin
                cond = $signed(sr0) < $signed(sr1);
            end
            br_bge: begin
                cond = $signed(sr0) >= $signed(sr1);
            end
            br_bltu: begin
                cond = sr0 < sr1;
            end
            br_bgeu: begin
                cond = sr0 >= sr1;
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    // jirl is register-relative, everything else pc-relative
    assign target = ((op == br_jirl) ? sr0 : pc) + imm;

    // fall-through address doubles as the link value
    assign link    = pc + `EXE_LINK_OFS;
    assign link_en = en && ((op == br_bl) || (op == br_jirl));

    assign taken       = en && cond;
    assign actual_next = taken ? target : link;
    assign mispredict  = en && (actual_next != pc_next);

endmodule

/* exe_alu.sv */
module exe_alu import exe_pkg::*; (
    input  alu_op_t op,
    input  data_t   sr0,
    input  data_t   sr1,
    output data_t   result
);

    logic [4:0] shamt;

    assign shamt = sr1[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                result = sr0 + sr1;
            end
            alu_sub: begin
                result = sr0 - sr1;
            end
            alu_slt: begin
                result = {31'b0, $signed(sr0) < $signed(sr1)};
            end
            alu_sltu: begin
                result = {31'b0, sr0 < sr1};
            end
            alu_and: begin
                result = sr0 & sr1;
            end
            alu_or: begin
                result = sr0 | sr1;
            end
            alu_xor: begin
                result = sr0 ^ sr1;
            end
            alu_nor: begin
                result = ~(sr0 | sr1);
            end
            alu_sll: begin
                result = sr0 << shamt;
            end
            alu_srl: begin
                result = sr0 >> shamt;
            end
            alu_sra: begin
                result = $signed(sr0) >>> shamt;
            end
            // immediate is already shifted by decode
            default: begin
                result = sr1;
            end
        endcase
    end

endmodule

/* exe_bypass_if.sv */
interface exe_bypass_if import exe_pkg::*; ();

    // eu0 result of this stage
    logic      en0;
    reg_addr_t rd0;
    data_t     data0;

    // eu1 result of this stage, younger than eu0
    logic      en1;
    reg_addr_t rd1;
    data_t     data1;

    modport writer (
        output en0,
        output rd0,
        output data0,
        output en1,
        output rd1,
        output data1
    );

    modport reader (
        input en0,
        input rd0,
        input data0,
        input en1,
        input rd1,
        input data1
    );

endinterface

/* exe_pkg.sv */
`include "exe_macros.svh"

package exe_pkg;

    typedef logic [`EXE_DATA_W-1:0] data_t;
    typedef logic [`EXE_DATA_W-1:0] pc_t;
    // register 0 is hardwired to zero and never written
    typedef logic [`EXE_REG_W-1:0]  reg_addr_t;
    // raw op field; for multiply, bit 0 picks the high word and bit 1 signed operands
    typedef logic [`EXE_OP_W-1:0]   exe_op_t;

    // unit selected in slot eu0
    typedef enum logic [1:0] {
        unit_alu,
        unit_mul,
        unit_br
    } exe_unit_t;

    typedef enum logic [`EXE_OP_W-1:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [`EXE_OP_W-1:0] {
        br_jirl = `EXE_BR_JIRL,
        br_b    = `EXE_BR_B,
        br_bl   = `EXE_BR_BL,
        br_beq  = `EXE_BR_BEQ,
        br_bne  = `EXE_BR_BNE,
        br_blt  = `EXE_BR_BLT,
        br_bge  = `EXE_BR_BGE,
        br_bltu = `EXE_BR_BLTU,
        br_bgeu = `EXE_BR_BGEU
    } branch_op_t;

endpackage

/* exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// datapath widths
`define EXE_DATA_W    32
`define EXE_REG_W     5
`define EXE_OP_W      4

// return address is the next sequential instruction
`define EXE_LINK_OFS  4

// branch op codes carried in the op field of slot eu0
`define EXE_BR_JIRL   3
`define EXE_BR_B      4
`define EXE_BR_BL     5
`define EXE_BR_BEQ    6
`define EXE_BR_BNE    7
`define EXE_BR_BLT    8
`define EXE_BR_BGE    9
`define EXE_BR_BLTU   10
`define EXE_BR_BGEU   11

`endif
